/* hw/lc3b_defines.svh */
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// data and address width, one LC-3b word
`define LC3B_WORD_W 16

// register index, also the n/z/p request field of a branch
`define LC3B_REG_W 3

// condition codes n, z, p
`define LC3B_NZP_W 3

// opcode field, instruction bits 15..12
`define LC3B_OPC_W 4

`endif

/* hw/lc3b_pkg.sv */
`include "lc3b_defines.svh"

package lc3b_pkg;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [`LC3B_REG_W-1:0] lc3b_reg;
    typedef logic [`LC3B_NZP_W-1:0] lc3b_nzp;

    // LC-3b opcode encodings, instruction bits 15..12
    typedef enum logic [`LC3B_OPC_W-1:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // data-memory address source
    typedef enum logic [2:0] {
        marmux_alu    = 3'd0,
        marmux_pc     = 3'd1,
        marmux_br_add = 3'd2,
        marmux_rdata  = 3'd3,   // indirect, pointer from memory
        marmux_trap   = 3'd4
    } marmux_sel_t;

    // store-data source
    typedef enum logic [1:0] {
        mdrmux_alu      = 2'd0,
        mdrmux_rdata    = 2'd1,
        mdrmux_sr1_high = 2'd2, // byte store, sr1 low byte moved up
        mdrmux_sr2      = 2'd3
    } mdrmux_sel_t;

    // register-file write-back source
    typedef enum logic [2:0] {
        rfmux_alu    = 3'd0,
        rfmux_rdata  = 3'd1,
        rfmux_br_add = 3'd2,
        rfmux_pc     = 3'd3,
        rfmux_zext8  = 3'd4,
        rfmux_shift  = 3'd5,
        rfmux_ldb    = 3'd6
    } regfilemux_sel_t;

    typedef struct packed {
        lc3b_opcode      opcode;
        marmux_sel_t     marmux_sel;
        mdrmux_sel_t     mdrmux_sel;
        regfilemux_sel_t regfilemux_sel;
        logic            mem_read;
        logic            mem_write;
        logic [1:0]      mem_byte_enable;   // bit 1 high byte, bit 0 low byte
        logic            load_cc;
        logic            load_regfile;
    } lc3b_control_word;

    // execute results entering the memory stage
    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_word         alu_out;
        lc3b_word         pc_out;
        lc3b_word         br_add_out;
        lc3b_word         sr1_out;
        lc3b_word         sr2_out;
        lc3b_word         instruction;
        lc3b_reg          dest;
    } ex_mem_t;

    typedef struct packed {
        lc3b_word regfile_data;
        lc3b_reg  dest;
        logic     load_regfile;
    } mem_wb_t;

endpackage

/* hw/ex_mem_latch.sv */
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module ex_mem_latch (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             in_valid,
    input  lc3b_pkg::ex_mem_t in_bundle,
    output logic             ex_valid,
    output lc3b_pkg::ex_mem_t ex_bundle
);

    import lc3b_pkg::*;

    // valid level, cleared on reset and frozen during a stall
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ex_valid <= 1'b0;
        end
        else if (!stall)
        begin
            ex_valid <= in_valid;
        end
    end

    // bundle payload follows the same load enable
    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            ex_bundle <= in_bundle;    // don't care while ex_valid is low
        end
    end

endmodule

/* hw/mem_datapath.sv */
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module mem_datapath (
    input  logic                clk,
    input  logic                rst,
    input  logic                ex_valid,
    input  lc3b_pkg::ex_mem_t   ex_bundle,
    input  logic                cc_commit,
    input  lc3b_pkg::lc3b_word  rdata,
    output lc3b_pkg::lc3b_word  address,
    output lc3b_pkg::lc3b_word  wdata,
    output logic                read,
    output logic                write,
    output logic [1:0]          wmask,
    output lc3b_pkg::lc3b_word  regfile_data,
    output logic                br_en
);

    import lc3b_pkg::*;

    lc3b_control_word ctrl;
    lc3b_word         instr;
    lc3b_word         trap_vec;
    lc3b_word         zext8_out;
    lc3b_word         ldb_out;
    lc3b_word         shift_out;
    logic [7:0]       ldb_byte;
    logic [3:0]       shamt;
    lc3b_nzp          gencc;
    lc3b_nzp          cc;

    assign ctrl  = ex_bundle.ctrl;
    assign instr = ex_bundle.instruction;

    // trap vector is trapvect8 scaled to a word address
    assign trap_vec = {{(`LC3B_WORD_W-9){1'b0}}, instr[7:0], 1'b0};

    // strobes only while a bundle is present
    assign read  = ex_valid & ctrl.mem_read;
    assign write = ex_valid & ctrl.mem_write;
    assign wmask = {2{ex_valid}} & ctrl.mem_byte_enable;

    always_comb
    begin
        unique case (ctrl.marmux_sel)
            marmux_alu:    address = ex_bundle.alu_out;
            marmux_pc:     address = ex_bundle.pc_out;
            marmux_br_add: address = ex_bundle.br_add_out;
            marmux_rdata:  address = rdata;
            marmux_trap:   address = trap_vec;
            default:       address = '0;
        endcase
    end

    always_comb
    begin
        unique case (ctrl.mdrmux_sel)
            mdrmux_alu:      wdata = ex_bundle.alu_out;
            mdrmux_rdata:    wdata = rdata;
            mdrmux_sr1_high: wdata = {ex_bundle.sr1_out[7:0], 8'h00};
            mdrmux_sr2:      wdata = ex_bundle.sr2_out;
            default:         wdata = '0;
        endcase
    end

    // byte lane picked by the low address bit
    assign ldb_byte  = address[0] ? rdata[15:8] : rdata[7:0];
    assign ldb_out   = {8'h00, ldb_byte};
    assign zext8_out = {8'h00, rdata[7:0]};

    // shf: bit 4 is direction (1 right), bit 5 arithmetic
    assign shamt = instr[3:0];

    always_comb
    begin
        if (!instr[4])
            shift_out = ex_bundle.sr1_out << shamt;
        else if (!instr[5])
            shift_out = ex_bundle.sr1_out >> shamt;
        else
            shift_out = $signed(ex_bundle.sr1_out) >>> shamt;   // keeps the sign bit
    end

    always_comb
    begin
        unique case (ctrl.regfilemux_sel)
            rfmux_alu:    regfile_data = ex_bundle.alu_out;
            rfmux_rdata:  regfile_data = rdata;
            rfmux_br_add: regfile_data = ex_bundle.br_add_out;
            rfmux_pc:     regfile_data = ex_bundle.pc_out;
            rfmux_zext8:  regfile_data = zext8_out;
            rfmux_shift:  regfile_data = shift_out;
            rfmux_ldb:    regfile_data = ldb_out;
            default:      regfile_data = '0;
        endcase
    end

    // n z p of the value being written back
    assign gencc[2] = regfile_data[`LC3B_WORD_W-1];
    assign gencc[1] = (regfile_data == '0);
    assign gencc[0] = ~regfile_data[`LC3B_WORD_W-1] & (regfile_data != '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cc <= '0;
        end
        else if (cc_commit)
        begin
            cc <= gencc;    // only completed bundles touch cc
        end
    end

    // dest carries the n z p request bits of a branch
    assign br_en = ex_valid & (ctrl.opcode == op_br) & (|(ex_bundle.dest & cc));

endmodule

/* hw/mem_wb_latch.sv */
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module mem_wb_latch (
    input  logic               clk,
    input  logic               rst,
    input  logic               ex_valid,
    input  lc3b_pkg::ex_mem_t  ex_bundle,
    input  logic               resp,
    input  lc3b_pkg::lc3b_word regfile_data,
    output logic               stall,
    output logic               cc_commit,
    output logic               wb_valid,
    output lc3b_pkg::mem_wb_t  wb_bundle
);

    import lc3b_pkg::*;

    logic    mem_access;
    logic    complete;
    mem_wb_t wb_next;

    assign mem_access = ex_bundle.ctrl.mem_read | ex_bundle.ctrl.mem_write;

    // done this cycle if nothing to wait for, or the memory answered
    assign complete = ex_valid & (~mem_access | resp);
    assign stall    = ex_valid & mem_access & ~resp;

    assign cc_commit = complete & ex_bundle.ctrl.load_cc;

    assign wb_next.regfile_data = regfile_data;
    assign wb_next.dest         = ex_bundle.dest;
    assign wb_next.load_regfile = ex_bundle.ctrl.load_regfile;

    // one pulse per completed bundle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_valid <= 1'b0;
        end
        else
        begin
            wb_valid <= complete;
        end
    end

    always_ff @(posedge clk)
    begin
        if (complete)
        begin
            wb_bundle <= wb_next;   // rdata is only valid alongside resp
        end
    end

endmodule

/* hw/mem_stage_top.sv */
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module mem_stage_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  lc3b_pkg::ex_mem_t  in_bundle,
    output lc3b_pkg::lc3b_word address,
    output lc3b_pkg::lc3b_word wdata,
    output logic               read,
    output logic               write,
    output logic [1:0]         wmask,
    input  lc3b_pkg::lc3b_word rdata,
    input  logic               resp,
    output logic               stall,
    output logic               br_en,
    output logic               wb_valid,
    output lc3b_pkg::mem_wb_t  wb_bundle
);

    import lc3b_pkg::*;

    logic     ex_valid;
    ex_mem_t  ex_bundle;
    logic     cc_commit;
    lc3b_word regfile_data;

    ex_mem_latch ex_mem_latch0 (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .in_valid  (in_valid),
        .in_bundle (in_bundle),
        .ex_valid  (ex_valid),
        .ex_bundle (ex_bundle)
    );

    mem_datapath mem_datapath0 (
        .clk          (clk),
        .rst          (rst),
        .ex_valid     (ex_valid),
        .ex_bundle    (ex_bundle),
        .cc_commit    (cc_commit),
        .rdata        (rdata),
        .address      (address),
        .wdata        (wdata),
        .read         (read),
        .write        (write),
        .wmask        (wmask),
        .regfile_data (regfile_data),
        .br_en        (br_en)
    );

    mem_wb_latch mem_wb_latch0 (
        .clk          (clk),
        .rst          (rst),
        .ex_valid     (ex_valid),
        .ex_bundle    (ex_bundle),
        .resp         (resp),
        .regfile_data (regfile_data),
        .stall        (stall),
        .cc_commit    (cc_commit),
        .wb_valid     (wb_valid),
        .wb_bundle    (wb_bundle)
    );

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;    // 20 ns period
    end

endmodule

/* bench/mem_stage_tb.sv */
`timescale 1ns/1ps

module mem_stage_tb;

    import lc3b_pkg::*;

    localparam int num_bundles = 200;
    localparam int max_cycles  = 2000;    // 200 bundles at up to 6 cycles each, plus margin

    // opcode, addr src, store src, wb src, read, write, byte enable, load_cc, load_regfile
    localparam lc3b_control_word ctrl_table [10] = '{
        '{op_add, marmux_alu, mdrmux_alu, rfmux_alu, 1'b0, 1'b0, 2'b00, 1'b1, 1'b1},
        '{op_lea, marmux_alu, mdrmux_alu, rfmux_br_add, 1'b0, 1'b0, 2'b00, 1'b0, 1'b1},
        '{op_jsr, marmux_alu, mdrmux_alu, rfmux_pc, 1'b0, 1'b0, 2'b00, 1'b0, 1'b1},
        '{op_shf, marmux_alu, mdrmux_alu, rfmux_shift, 1'b0, 1'b0, 2'b00, 1'b1, 1'b1},
        '{op_ldr, marmux_alu, mdrmux_alu, rfmux_rdata, 1'b1, 1'b0, 2'b11, 1'b1, 1'b1},
        '{op_ldb, marmux_alu, mdrmux_alu, rfmux_ldb, 1'b1, 1'b0, 2'b11, 1'b1, 1'b1},
        '{op_ldi, marmux_rdata, mdrmux_alu, rfmux_rdata, 1'b1, 1'b0, 2'b11, 1'b1, 1'b1},
        '{op_str, marmux_alu, mdrmux_sr2, rfmux_alu, 1'b0, 1'b1, 2'b11, 1'b0, 1'b0},
        '{op_stb, marmux_alu, mdrmux_sr1_high, rfmux_alu, 1'b0, 1'b1, 2'b10, 1'b0, 1'b0},
        '{op_br, marmux_alu, mdrmux_alu, rfmux_alu, 1'b0, 1'b0, 2'b00, 1'b0, 1'b0}
    };

    logic       clk, rst, in_valid, read, write, resp, stall, br_en, wb_valid;
    logic [1:0] wmask;
    lc3b_word   address, wdata, rdata;
    ex_mem_t    in_bundle;
    mem_wb_t    wb_bundle;

    lc3b_word   mem [256];
    mem_wb_t    exp_q [$];
    ex_mem_t    cur;                        // bundle the model holds in the input latch
    mem_wb_t    cur_wb;
    logic       cur_valid, model_stall, wb_due, taken, busy;
    lc3b_nzp    model_cc;
    integer     seed;
    int         wait_left, errors, issued, checked, cycles;

    tb_clock_gen clock_gen0 (.clk(clk));

    mem_stage_top dut0 (.*);

    function automatic lc3b_nzp cc_of(lc3b_word v);
        return {$signed(v) < 0, v == 16'h0000, $signed(v) > 0};
    endfunction

    // write-back value from the LC-3b rules, memory read when the bundle is accepted
    function automatic lc3b_word expect_value(ex_mem_t b, lc3b_word ptr);
        lc3b_word   a;
        lc3b_word   word;
        lc3b_word   s;
        logic [3:0] n;
        a    = (b.ctrl.marmux_sel == marmux_rdata) ? ptr : b.alu_out;
        word = mem[a[8:1]];
        s    = b.sr1_out;
        n    = b.instruction[3:0];
        case (b.ctrl.regfilemux_sel)
            rfmux_rdata:  return word;
            rfmux_ldb:    return a[0] ? {8'h00, word[15:8]} : {8'h00, word[7:0]};
            rfmux_br_add: return b.br_add_out;
            rfmux_pc:     return b.pc_out;
            rfmux_shift:  return !b.instruction[4] ? s << n : !b.instruction[5] ? s >> n
                              : (s >> n) | (~(16'hffff >> n) & {16{s[15]}});   // sign fill
            default:      return b.alu_out;
        endcase
    endfunction

    function automatic ex_mem_t make_bundle(int kind);
        ex_mem_t b;
        b.ctrl        = ctrl_table[kind];
        b.alu_out     = 16'($random(seed));
        b.pc_out      = 16'($random(seed));
        b.br_add_out  = 16'($random(seed));
        b.sr1_out     = 16'($random(seed));
        b.sr2_out     = 16'($random(seed));
        b.instruction = 16'($random(seed));
        b.dest        = 3'($random(seed));
        if (b.ctrl.mem_read || b.ctrl.mem_write)
            b.alu_out = b.alu_out & 16'h003f;   // small window so loads hit earlier stores
        return b;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // reference model and checks on the rising edge, before any DUT register moves
    always @(posedge clk)
    begin
        cycles++;
        if (rst)
        begin
            cur_valid = 1'b0;
            model_cc  = '0;
            wb_due    = 1'b0;
            taken     = 1'b0;
        end
        else
        begin
            model_stall = cur_valid && (cur.ctrl.mem_read || cur.ctrl.mem_write) && !resp;
            check_value("read", read, cur_valid && cur.ctrl.mem_read);
            check_value("write", write, cur_valid && cur.ctrl.mem_write);
            check_value("wmask", wmask, cur_valid ? cur.ctrl.mem_byte_enable : 2'b00);
            check_value("stall", stall, model_stall);
            check_value("br_en", br_en,
                cur_valid && cur.ctrl.opcode == op_br && (cur.dest & model_cc) != 0);
            check_value("wb_valid", wb_valid, wb_due);
            if (cur_valid && (cur.ctrl.mem_read || cur.ctrl.mem_write))
                check_value("address", address,
                    (cur.ctrl.marmux_sel == marmux_rdata) ? rdata : cur.alu_out);
            if (cur_valid && cur.ctrl.mem_write)
                check_value("wdata", wdata, (cur.ctrl.mdrmux_sel == mdrmux_sr1_high)
                    ? {cur.sr1_out[7:0], 8'h00} : cur.sr2_out);
            if (wb_valid && exp_q.size() == 0)
            begin
                errors++;
                $display("write-back pulse arrived with no bundle outstanding");
            end
            else if (wb_valid)
            begin
                check_value("wb_bundle", wb_bundle, exp_q.pop_front());
                checked++;
            end
            wb_due = cur_valid && !model_stall;     // completes on this edge
            if (wb_due && cur.ctrl.load_cc)
                model_cc = cc_of(cur_wb.regfile_data);
            taken = in_valid && !model_stall;
            if (!model_stall)
            begin
                cur_valid = in_valid;
                cur       = in_bundle;
                cur_wb    = '{expect_value(in_bundle, rdata), in_bundle.dest,
                              in_bundle.ctrl.load_regfile};
                if (in_valid)
                    exp_q.push_back(cur_wb);
            end
        end
        if (cycles >= max_cycles)
        begin
            $display("timeout after %0d cycles with %0d of %0d write-backs seen",
                cycles, checked, num_bundles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // memory model and stimulus share one falling-edge process
    always @(negedge clk)
    begin
        resp = 1'b0;
        if (read || write)
        begin
            if (!busy)
            begin
                busy      = 1'b1;
                wait_left = $random(seed) & 3;  // 0 to 3 cycles of latency
            end
            if (wait_left > 0)
                wait_left--;
            else
            begin
                busy = 1'b0;
                resp = 1'b1;
                if (write && wmask[0])
                    mem[address[8:1]][7:0] = wdata[7:0];
                if (write && wmask[1])
                    mem[address[8:1]][15:8] = wdata[15:8];
                if (read)
                    rdata = mem[address[8:1]];  // held until the next response
            end
        end
        if (cycles > 4 && (!in_valid || taken))
        begin
            if (issued < num_bundles)
            begin
                in_bundle = make_bundle($unsigned($random(seed)) % 10);
                in_valid  = 1'b1;
                issued++;
            end
            else
                in_valid = 1'b0;
        end
    end

    initial
    begin
        seed      = 87066;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_bundle = '0;
        rdata     = '0;
        resp      = 1'b0;
        busy      = 1'b0;
        wait_left = 0;
        errors    = 0;
        issued    = 0;
        checked   = 0;
        cycles    = 0;
        for (int i = 0; i < 256; i++)
            mem[i] = 16'((i * 40503) ^ 16'hc3a5);   // every address bit shapes the word
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait (checked == num_bundles);
        repeat (4) @(negedge clk);
        $display("errors: %0d, write-backs checked: %0d of %0d", errors, checked, num_bundles);
        if (errors == 0 && exp_q.size() == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* mem_stage_top.f */
+incdir+hw
hw/lc3b_pkg.sv
hw/ex_mem_latch.sv
hw/mem_datapath.sv
hw/mem_wb_latch.sv
hw/mem_stage_top.sv
bench/tb_clock_gen.sv
bench/mem_stage_tb.sv

/* Bender.yml */
package:
  name: mem_stage

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/lc3b_pkg.sv
      - hw/ex_mem_latch.sv
      - hw/mem_datapath.sv
      - hw/mem_wb_latch.sv
      - hw/mem_stage_top.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/mem_stage_tb.sv
